// File: verilog/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Data and address width
`define XLEN 64

`define INSTR_W 32

`define REG_ADDR_W 5

`define NUM_REGS 32

// Hardwired zero register, reads as 0 and is never written
`define ZERO_REG 31

// One instruction word per fetch
`define PC_STEP 4

`define RESET_PC 0

`endif

// File: verilog/isa_pkg.sv
`include "cpu_consts.svh"

package isa_pkg;

  typedef logic [`XLEN-1:0]       xword_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [`INSTR_W-1:0]    instr_t;
  typedef logic [10:0]            opcode_t;

  localparam opcode_t    OP_ADD  = 11'b10001011000;
  localparam opcode_t    OP_SUB  = 11'b11001011000;
  localparam opcode_t    OP_AND  = 11'b10001010000;
  localparam opcode_t    OP_ORR  = 11'b10101010000;
  localparam opcode_t    OP_LDUR = 11'b11111000010;
  localparam opcode_t    OP_STUR = 11'b11111000000;
  localparam logic [7:0] OP_CBZ  = 8'b10110100;    // Top 8 bits only
  localparam logic [5:0] OP_B    = 6'b000101;      // Top 6 bits only

  typedef struct packed {
    opcode_t    opcode;
    reg_addr_t  rm;
    logic [5:0] shamt;
    reg_addr_t  rn;
    reg_addr_t  rd;
  } r_fmt_t;

  typedef struct packed {
    opcode_t    opcode;
    logic [8:0] addr;  // Signed word offset
    logic [1:0] op2;
    reg_addr_t  rn;
    reg_addr_t  rt;
  } d_fmt_t;

  typedef struct packed {
    logic [7:0]  opcode;
    logic [18:0] addr;  // Signed instruction offset
    reg_addr_t   rt;
  } cb_fmt_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] addr;  // Signed instruction offset
  } b_fmt_t;

  typedef enum logic [3:0] {
    ALU_AND    = 4'b0000,
    ALU_ORR    = 4'b0001,
    ALU_ADD    = 4'b0010,
    ALU_SUB    = 4'b0110,
    ALU_PASS_B = 4'b0111
  } alu_op_e;

endpackage

// File: verilog/pipe_pkg.sv
package pipe_pkg;

  // ALU class carried from decode to the ALU control
  localparam logic [1:0] ALU_CLASS_MEM = 2'b00;  // Address add
  localparam logic [1:0] ALU_CLASS_BR  = 2'b01;  // Pass operand b for CBZ test
  localparam logic [1:0] ALU_CLASS_R   = 2'b10;  // Function from opcode

  typedef struct packed {
    logic [1:0] alu_class;
    logic       alu_src;        // Immediate as operand b
    logic       zero_branch;
    logic       uncond_branch;
    logic       mem_read;
    logic       mem_write;
    logic       reg_write;
    logic       mem_to_reg;
  } ctrl_t;

  typedef struct packed {
    isa_pkg::xword_t pc;
    isa_pkg::instr_t instr;
  } ifid_t;

  typedef struct packed {
    logic               valid;
    ctrl_t              ctrl;
    isa_pkg::xword_t    pc;
    isa_pkg::xword_t    op_a;
    isa_pkg::xword_t    op_b;
    isa_pkg::xword_t    imm;
    isa_pkg::opcode_t   opcode;
    isa_pkg::reg_addr_t dest;
    isa_pkg::reg_addr_t src_a;
    isa_pkg::reg_addr_t src_b;
  } idex_t;

  typedef struct packed {
    logic               valid;
    logic               mem_read;
    logic               mem_write;
    logic               reg_write;
    logic               mem_to_reg;
    logic               zero_branch;
    logic               uncond_branch;
    isa_pkg::xword_t    branch_target;
    logic               zero;
    isa_pkg::xword_t    alu_result;
    isa_pkg::xword_t    store_data;
    isa_pkg::reg_addr_t dest;
  } exmem_t;

  typedef struct packed {
    logic               valid;
    logic               reg_write;
    logic               mem_to_reg;
    isa_pkg::xword_t    alu_result;
    isa_pkg::xword_t    load_data;
    isa_pkg::reg_addr_t dest;
  } memwb_t;

endpackage

// File: verilog/stage_reg.sv
module stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     CLOCK,
  input  logic     rst,
  input  logic     en,
  input  logic     flush,
  input  payload_t d,
  output payload_t q
);

  always_ff @(posedge CLOCK) begin
    if (rst || flush) begin
      q <= '0;  // Bubble
    end else if (en) begin
      q <= d;
    end
  end

endmodule

// File: verilog/fetch_unit.sv
`include "cpu_consts.svh"

module fetch_unit (
  input  logic            CLOCK,
  input  logic            rst,
  input  logic            stall,
  input  logic            branch_taken,
  input  isa_pkg::xword_t branch_target,
  output isa_pkg::xword_t pc
);

  isa_pkg::xword_t pc_next;

  always_comb begin
    if (branch_taken) begin
      pc_next = branch_target;  // Redirect wins over a load-use stall
    end else if (stall) begin
      pc_next = pc;
    end else begin
      pc_next = pc + isa_pkg::xword_t'(`PC_STEP);
    end
  end

  always_ff @(posedge CLOCK) begin
    if (rst) begin
      pc <= isa_pkg::xword_t'(`RESET_PC);
    end else begin
      pc <= pc_next;
    end
  end

endmodule

// File: verilog/reg_file.sv
`include "cpu_consts.svh"

module reg_file (
  input  logic               CLOCK,
  input  logic               rst,
  input  isa_pkg::reg_addr_t rd_a,
  input  isa_pkg::reg_addr_t rd_b,
  output isa_pkg::xword_t    rd_a_data,
  output isa_pkg::xword_t    rd_b_data,
  input  logic               wr_en,
  input  isa_pkg::reg_addr_t wr_reg,
  input  isa_pkg::xword_t    wr_data
);

  isa_pkg::xword_t regs [`NUM_REGS];

  // x31 reads as zero, a same-cycle write is seen by decode
  function automatic isa_pkg::xword_t read_port(isa_pkg::reg_addr_t addr);
    if (addr == `ZERO_REG) begin
      return '0;
    end else if (wr_en && (wr_reg == addr)) begin
      return wr_data;
    end
    return regs[addr];
  endfunction

  always_comb begin
    rd_a_data = read_port(rd_a);
    rd_b_data = read_port(rd_b);
  end

  always_ff @(posedge CLOCK) begin
    if (rst) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= (i == `ZERO_REG) ? '0 : isa_pkg::xword_t'(i);  // x_i holds i
      end
    end else if (wr_en && (wr_reg != `ZERO_REG)) begin
      regs[wr_reg] <= wr_data;
    end
  end

endmodule

// File: verilog/decode_unit.sv
`include "cpu_consts.svh"

module decode_unit (
  input  pipe_pkg::ifid_t    ifid,
  input  logic               ex_mem_read,
  input  isa_pkg::reg_addr_t ex_dest,
  output isa_pkg::reg_addr_t rd_a,
  output isa_pkg::reg_addr_t rd_b,
  input  isa_pkg::xword_t    rd_a_data,
  input  isa_pkg::xword_t    rd_b_data,
  output logic               stall,
  output pipe_pkg::idex_t    idex
);

  isa_pkg::r_fmt_t  r_fmt;
  isa_pkg::d_fmt_t  d_fmt;
  isa_pkg::cb_fmt_t cb_fmt;
  isa_pkg::b_fmt_t  b_fmt;
  pipe_pkg::ctrl_t  ctrl;
  isa_pkg::xword_t  imm;
  logic             known;
  logic             use_a;
  logic             use_b;

  // Same word seen through each format
  assign r_fmt  = ifid.instr;
  assign d_fmt  = ifid.instr;
  assign cb_fmt = ifid.instr;
  assign b_fmt  = ifid.instr;

  always_comb begin
    ctrl  = '0;
    known = 1'b1;
    use_a = 1'b0;
    use_b = 1'b0;
    if (b_fmt.opcode == isa_pkg::OP_B) begin
      ctrl.alu_class     = pipe_pkg::ALU_CLASS_BR;
      ctrl.uncond_branch = 1'b1;
    end else if (cb_fmt.opcode == isa_pkg::OP_CBZ) begin
      ctrl.alu_class   = pipe_pkg::ALU_CLASS_BR;
      ctrl.zero_branch = 1'b1;
      use_b            = 1'b1;  // Rt tested against zero
    end else begin
      case (r_fmt.opcode)
        isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_AND, isa_pkg::OP_ORR: begin
          ctrl.alu_class = pipe_pkg::ALU_CLASS_R;
          ctrl.reg_write = 1'b1;
          use_a          = 1'b1;
          use_b          = 1'b1;
        end
        isa_pkg::OP_LDUR: begin
          ctrl.alu_class  = pipe_pkg::ALU_CLASS_MEM;
          ctrl.alu_src    = 1'b1;
          ctrl.mem_read   = 1'b1;
          ctrl.reg_write  = 1'b1;
          ctrl.mem_to_reg = 1'b1;
          use_a           = 1'b1;
        end
        isa_pkg::OP_STUR: begin
          ctrl.alu_class = pipe_pkg::ALU_CLASS_MEM;
          ctrl.alu_src   = 1'b1;
          ctrl.mem_write = 1'b1;
          use_a          = 1'b1;
          use_b          = 1'b1;  // Store data from Rt
        end
        default: known = 1'b0;
      endcase
    end
    if (r_fmt.rd == `ZERO_REG) begin
      ctrl.reg_write = 1'b0;  // Writes to x31 are dropped here
    end
  end

  assign rd_a = r_fmt.rn;
  assign rd_b = ifid.instr[28] ? d_fmt.rt : r_fmt.rm;  // Rt for STUR and CBZ

  always_comb begin
    if (b_fmt.opcode == isa_pkg::OP_B) begin
      imm = {{(`XLEN-26){b_fmt.addr[25]}}, b_fmt.addr};
    end else if (cb_fmt.opcode == isa_pkg::OP_CBZ) begin
      imm = {{(`XLEN-19){cb_fmt.addr[18]}}, cb_fmt.addr};
    end else begin
      imm = {{(`XLEN-9){d_fmt.addr[8]}}, d_fmt.addr};  // Unused by R-type
    end
  end

  // Load in EX feeding this instruction, wait one cycle
  assign stall = known && ex_mem_read && (ex_dest != `ZERO_REG) &&
                 ((use_a && (ex_dest == rd_a)) || (use_b && (ex_dest == rd_b)));

  always_comb begin
    idex = '0;
    if (known && !stall) begin
      idex.valid  = 1'b1;
      idex.ctrl   = ctrl;
      idex.pc     = ifid.pc;
      idex.op_a   = rd_a_data;
      idex.op_b   = rd_b_data;
      idex.imm    = imm;
      idex.opcode = r_fmt.opcode;
      idex.dest   = r_fmt.rd;
      idex.src_a  = rd_a;
      idex.src_b  = rd_b;
    end
  end

endmodule

// File: verilog/execute_unit.sv
`include "cpu_consts.svh"

module execute_unit (
  input  pipe_pkg::idex_t    idex,
  input  isa_pkg::reg_addr_t mem_dest,
  input  isa_pkg::reg_addr_t wb_dest,
  input  logic               mem_fwd_en,
  input  logic               wb_fwd_en,
  input  isa_pkg::xword_t    mem_fwd_data,
  input  isa_pkg::xword_t    wb_fwd_data,
  output pipe_pkg::exmem_t   exmem
);

  isa_pkg::xword_t  fwd_a;
  isa_pkg::xword_t  fwd_b;
  isa_pkg::xword_t  alu_b;
  isa_pkg::xword_t  result;
  isa_pkg::alu_op_e alu_op;

  // EX/MEM is newer than MEM/WB, so it is checked first
  function automatic isa_pkg::xword_t forward(isa_pkg::reg_addr_t src,
                                              isa_pkg::xword_t reg_val);
    if (src == `ZERO_REG) begin
      return reg_val;
    end else if (mem_fwd_en && (mem_dest == src)) begin
      return mem_fwd_data;
    end else if (wb_fwd_en && (wb_dest == src)) begin
      return wb_fwd_data;
    end
    return reg_val;
  endfunction

  always_comb begin
    fwd_a = forward(idex.src_a, idex.op_a);
    fwd_b = forward(idex.src_b, idex.op_b);
  end

  assign alu_b = idex.ctrl.alu_src ? idex.imm : fwd_b;

  always_comb begin
    case (idex.ctrl.alu_class)
      pipe_pkg::ALU_CLASS_MEM: alu_op = isa_pkg::ALU_ADD;
      pipe_pkg::ALU_CLASS_BR:  alu_op = isa_pkg::ALU_PASS_B;
      pipe_pkg::ALU_CLASS_R: begin
        case (idex.opcode)
          isa_pkg::OP_SUB: alu_op = isa_pkg::ALU_SUB;
          isa_pkg::OP_AND: alu_op = isa_pkg::ALU_AND;
          isa_pkg::OP_ORR: alu_op = isa_pkg::ALU_ORR;
          default:         alu_op = isa_pkg::ALU_ADD;
        endcase
      end
      default: alu_op = isa_pkg::ALU_ADD;  // Bubble
    endcase
  end

  always_comb begin
    case (alu_op)
      isa_pkg::ALU_AND: result = fwd_a & alu_b;
      isa_pkg::ALU_ORR: result = fwd_a | alu_b;
      isa_pkg::ALU_ADD: result = fwd_a + alu_b;
      isa_pkg::ALU_SUB: result = fwd_a - alu_b;
      default:          result = alu_b;
    endcase
  end

  always_comb begin
    exmem.valid         = idex.valid;
    exmem.mem_read      = idex.ctrl.mem_read;
    exmem.mem_write     = idex.ctrl.mem_write;
    exmem.reg_write     = idex.ctrl.reg_write;
    exmem.mem_to_reg    = idex.ctrl.mem_to_reg;
    exmem.zero_branch   = idex.ctrl.zero_branch;
    exmem.uncond_branch = idex.ctrl.uncond_branch;
    exmem.branch_target = idex.pc + (idex.imm << 2);  // Offset counts instructions
    exmem.zero          = (result == '0);
    exmem.alu_result    = result;
    exmem.store_data    = fwd_b;
    exmem.dest          = idex.dest;
  end

endmodule

// File: verilog/legv8_core.sv
module legv8_core (
  input  logic               CLOCK,
  input  logic               rst,
  output isa_pkg::xword_t    instr_addr,
  input  isa_pkg::instr_t    instr,
  output isa_pkg::xword_t    mem_addr,
  output isa_pkg::xword_t    mem_wdata,
  output logic               mem_read,
  output logic               mem_write,
  input  isa_pkg::xword_t    mem_rdata,
  output logic               wb_valid,
  output isa_pkg::reg_addr_t wb_reg,
  output isa_pkg::xword_t    wb_data
);

  pipe_pkg::ifid_t    ifid_d;
  pipe_pkg::ifid_t    ifid_q;
  pipe_pkg::idex_t    idex_d;
  pipe_pkg::idex_t    idex_q;
  pipe_pkg::exmem_t   exmem_d;
  pipe_pkg::exmem_t   exmem_q;
  pipe_pkg::memwb_t   memwb_d;
  pipe_pkg::memwb_t   memwb_q;
  isa_pkg::xword_t    pc;
  isa_pkg::xword_t    branch_target;
  isa_pkg::xword_t    rd_a_data;
  isa_pkg::xword_t    rd_b_data;
  isa_pkg::reg_addr_t rd_a;
  isa_pkg::reg_addr_t rd_b;
  logic               stall;
  logic               branch_taken;

  fetch_unit u_fetch (
    .CLOCK(CLOCK), .rst(rst), .stall(stall), .branch_taken(branch_taken),
    .branch_target(branch_target), .pc(pc)
  );

  assign instr_addr = pc;
  assign ifid_d     = '{pc: pc, instr: instr};

  stage_reg #(.payload_t(pipe_pkg::ifid_t)) u_ifid (
    .CLOCK(CLOCK), .rst(rst), .en(!stall), .flush(branch_taken), .d(ifid_d), .q(ifid_q)
  );

  decode_unit u_decode (
    .ifid(ifid_q), .ex_mem_read(idex_q.ctrl.mem_read), .ex_dest(idex_q.dest),
    .rd_a(rd_a), .rd_b(rd_b), .rd_a_data(rd_a_data), .rd_b_data(rd_b_data),
    .stall(stall), .idex(idex_d)
  );

  reg_file u_regs (
    .CLOCK(CLOCK), .rst(rst), .rd_a(rd_a), .rd_b(rd_b), .rd_a_data(rd_a_data),
    .rd_b_data(rd_b_data), .wr_en(wb_valid), .wr_reg(wb_reg), .wr_data(wb_data)
  );

  // Bubble on stall comes from decode itself
  stage_reg #(.payload_t(pipe_pkg::idex_t)) u_idex (
    .CLOCK(CLOCK), .rst(rst), .en(1'b1), .flush(branch_taken), .d(idex_d), .q(idex_q)
  );

  execute_unit u_execute (
    .idex(idex_q), .mem_dest(exmem_q.dest), .wb_dest(memwb_q.dest),
    .mem_fwd_en(exmem_q.reg_write), .wb_fwd_en(wb_valid),
    .mem_fwd_data(exmem_q.alu_result), .wb_fwd_data(wb_data), .exmem(exmem_d)
  );

  stage_reg #(.payload_t(pipe_pkg::exmem_t)) u_exmem (
    .CLOCK(CLOCK), .rst(rst), .en(1'b1), .flush(branch_taken), .d(exmem_d), .q(exmem_q)
  );

  // Branch resolves in MEM and squashes the three younger instructions
  assign branch_taken  = exmem_q.valid &&
                         (exmem_q.uncond_branch || (exmem_q.zero_branch && exmem_q.zero));
  assign branch_target = exmem_q.branch_target;

  assign mem_addr  = exmem_q.alu_result;  // Word index
  assign mem_wdata = exmem_q.store_data;
  assign mem_read  = exmem_q.mem_read;
  assign mem_write = exmem_q.mem_write;

  assign memwb_d = '{
    valid:      exmem_q.valid,
    reg_write:  exmem_q.reg_write,
    mem_to_reg: exmem_q.mem_to_reg,
    alu_result: exmem_q.alu_result,
    load_data:  mem_rdata,
    dest:       exmem_q.dest
  };

  stage_reg #(.payload_t(pipe_pkg::memwb_t)) u_memwb (
    .CLOCK(CLOCK), .rst(rst), .en(1'b1), .flush(1'b0), .d(memwb_d), .q(memwb_q)
  );

  assign wb_valid = memwb_q.valid && memwb_q.reg_write;
  assign wb_reg   = memwb_q.dest;
  assign wb_data  = memwb_q.mem_to_reg ? memwb_q.load_data : memwb_q.alu_result;

endmodule

// File: verif/tb_clock.sv
module tb_clock (
  input  logic reset_req,
  output logic CLOCK,
  output logic rst
);

  int reset_left;

  initial begin
    CLOCK      = 1'b0;
    rst        = 1'b1;  // Covers the first edge
    reset_left = 1;
  end

  always #20 CLOCK = ~CLOCK;  // Period 40

  // A request seen at an edge holds rst for the next two edges
  always @(posedge CLOCK) begin
    if (reset_req) begin
      reset_left = 2;
    end
    #1;
    rst = (reset_left > 0);
    if (reset_left > 0) begin
      reset_left--;
    end
  end

endmodule

// File: verif/legv8_props.sv
`include "cpu_consts.svh"

module legv8_props (
  input logic               CLOCK,
  input logic               rst,
  input logic               mem_read,
  input logic               mem_write,
  input logic               wb_valid,
  input isa_pkg::reg_addr_t wb_reg
);

  // One data access per cycle
  one_access: assert property (@(posedge CLOCK) disable iff (rst) !(mem_read && mem_write))
    else $error("mem_read and mem_write high in the same cycle");

  // Pipeline leaves reset empty
  quiet_after_reset: assert property (
    @(posedge CLOCK) $fell(rst) |-> (!wb_valid && !mem_read && !mem_write)
  ) else $error("core active in the first cycle after reset");

  no_zero_retire: assert property (
    @(posedge CLOCK) disable iff (rst) wb_valid |-> (wb_reg != `ZERO_REG)
  ) else $error("write to x31 retired");

endmodule

bind legv8_core legv8_props u_props (
  .CLOCK(CLOCK), .rst(rst), .mem_read(mem_read), .mem_write(mem_write),
  .wb_valid(wb_valid), .wb_reg(wb_reg)
);

// File: verif/legv8_tb.sv
`include "cpu_consts.svh"

module legv8_tb;

  localparam int ROM_WORDS  = 64;
  localparam int RAM_WORDS  = 256;
  localparam int MAX_CYCLES = 400;  // Six tests of about 40 cycles each

  logic               CLOCK;
  logic               rst;
  logic               reset_req;
  isa_pkg::xword_t    instr_addr;
  isa_pkg::instr_t    instr;
  isa_pkg::xword_t    mem_addr;
  isa_pkg::xword_t    mem_wdata;
  logic               mem_read;
  logic               mem_write;
  isa_pkg::xword_t    mem_rdata;
  logic               wb_valid;
  isa_pkg::reg_addr_t wb_reg;
  isa_pkg::xword_t    wb_data;

  isa_pkg::instr_t    rom [ROM_WORDS];
  isa_pkg::xword_t    ram [RAM_WORDS];
  isa_pkg::xword_t    model_regs [`NUM_REGS];
  isa_pkg::xword_t    model_ram [RAM_WORDS];
  isa_pkg::reg_addr_t exp_reg [$];
  isa_pkg::xword_t    exp_val [$];
  isa_pkg::xword_t    exp_addr [$];
  isa_pkg::xword_t    exp_data [$];
  int                 rom_fill;  // Next free ROM slot
  string              test_name;
  int                 test_errors;
  int                 total_errors;
  int                 tests_run;
  int                 tests_failed;
  int                 checks;
  int                 cycles;
  logic               pend_we;
  isa_pkg::xword_t    pend_addr;
  isa_pkg::xword_t    pend_data;

  tb_clock u_clock (.reset_req(reset_req), .CLOCK(CLOCK), .rst(rst));

  legv8_core uut (
    .CLOCK(CLOCK), .rst(rst), .instr_addr(instr_addr), .instr(instr),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_read(mem_read),
    .mem_write(mem_write), .mem_rdata(mem_rdata), .wb_valid(wb_valid),
    .wb_reg(wb_reg), .wb_data(wb_data)
  );

  // Past the program the ROM returns 0, which decodes as a bubble
  assign instr     = (instr_addr < ROM_WORDS * 4) ? rom[instr_addr[7:2]] : '0;
  assign mem_rdata = (mem_read && (mem_addr < RAM_WORDS)) ? ram[mem_addr[7:0]] : '0;

  always @(negedge CLOCK) begin
    if (!rst && wb_valid) begin
      check_wb(wb_reg, wb_data);
    end
    if (!rst && mem_write) begin
      check_store(mem_addr, mem_wdata);
      pend_we   = 1'b1;
      pend_addr = mem_addr;
      pend_data = mem_wdata;
    end
  end

  // Store lands just after the edge that ends its MEM cycle
  always @(posedge CLOCK) begin
    #1;
    if (pend_we && (pend_addr < RAM_WORDS)) begin
      ram[pend_addr[7:0]] = pend_data;
    end
    pend_we = 1'b0;
  end

  always @(posedge CLOCK) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic note_failure(string what);
    $display("%s: %s", test_name, what);
    test_errors++;
  endtask

  task automatic check_wb(isa_pkg::reg_addr_t reg_idx, isa_pkg::xword_t data);
    isa_pkg::reg_addr_t want_reg;
    isa_pkg::xword_t    want_val;
    checks++;
    if (exp_reg.size() == 0) begin
      note_failure($sformatf("unexpected write of %h to x%0d", data, reg_idx));
      return;
    end
    want_reg = exp_reg.pop_front();
    want_val = exp_val.pop_front();
    if (reg_idx != want_reg) begin
      $display("ERR %s: register expected x%0d actual x%0d", test_name, want_reg, reg_idx);
      test_errors++;
    end
    if (data != want_val) begin
      $display("ERR %s: x%0d expected %h actual %h", test_name, want_reg, want_val, data);
      test_errors++;
    end
  endtask

  task automatic check_store(isa_pkg::xword_t addr, isa_pkg::xword_t data);
    isa_pkg::xword_t want_addr;
    isa_pkg::xword_t want_data;
    checks++;
    if (exp_addr.size() == 0) begin
      note_failure($sformatf("unexpected store of %h to word %0d", data, addr));
      return;
    end
    want_addr = exp_addr.pop_front();
    want_data = exp_data.pop_front();
    if (addr != want_addr) begin
      $display("ERR %s: store address expected %h actual %h", test_name, want_addr, addr);
      test_errors++;
    end
    if (data != want_data) begin
      $display("ERR %s: store data expected %h actual %h", test_name, want_data, data);
      test_errors++;
    end
  endtask

  function automatic isa_pkg::xword_t reg_val(isa_pkg::reg_addr_t idx);
    return (idx == `ZERO_REG) ? '0 : model_regs[idx];
  endfunction

  function automatic isa_pkg::xword_t sext9(logic [8:0] off);
    return {{(`XLEN-9){off[8]}}, off};
  endfunction

  task automatic expect_write(isa_pkg::reg_addr_t rd, isa_pkg::xword_t val);
    if (rd != `ZERO_REG) begin  // x31 writes vanish
      model_regs[rd] = val;
      exp_reg.push_back(rd);
      exp_val.push_back(val);
    end
  endtask

  task automatic place_word(isa_pkg::instr_t word);
    rom[rom_fill] = word;
    rom_fill++;
  endtask

  task automatic alu_step(isa_pkg::opcode_t op, isa_pkg::reg_addr_t rd,
                          isa_pkg::reg_addr_t rn, isa_pkg::reg_addr_t rm);
    isa_pkg::xword_t a;
    isa_pkg::xword_t b;
    isa_pkg::xword_t res;
    a = reg_val(rn);
    b = reg_val(rm);
    case (op)
      isa_pkg::OP_SUB: res = a - b;
      isa_pkg::OP_AND: res = a & b;
      isa_pkg::OP_ORR: res = a | b;
      default:         res = a + b;
    endcase
    place_word({op, rm, 6'd0, rn, rd});
    expect_write(rd, res);
  endtask

  task automatic load_step(isa_pkg::reg_addr_t rt, isa_pkg::reg_addr_t rn, logic [8:0] off);
    isa_pkg::xword_t addr;
    addr = reg_val(rn) + sext9(off);
    place_word({isa_pkg::OP_LDUR, off, 2'b00, rn, rt});
    expect_write(rt, model_ram[addr[7:0]]);
  endtask

  task automatic store_step(isa_pkg::reg_addr_t rt, isa_pkg::reg_addr_t rn, logic [8:0] off);
    isa_pkg::xword_t addr;
    addr = reg_val(rn) + sext9(off);
    place_word({isa_pkg::OP_STUR, off, 2'b00, rn, rt});
    exp_addr.push_back(addr);
    exp_data.push_back(reg_val(rt));
    model_ram[addr[7:0]] = reg_val(rt);
  endtask

  // Three instructions that must be squashed behind a taken branch
  task automatic shadow_words();
    place_word({isa_pkg::OP_ADD, 5'd2, 6'd0, 5'd2, 5'd20});
    place_word({isa_pkg::OP_STUR, 9'd9, 2'b00, 5'd0, 5'd2});
    place_word({isa_pkg::OP_ORR, 5'd3, 6'd0, 5'd4, 5'd21});
  endtask

  task automatic prepare_test(string name);
    test_name   = name;
    test_errors = 0;
    @(posedge CLOCK);
    #1;
    reset_req = 1'b1;
    @(posedge CLOCK);
    #1;
    reset_req = 1'b0;
    wait (rst === 1'b1);
    exp_reg.delete();
    exp_val.delete();
    exp_addr.delete();
    exp_data.delete();
    for (int i = 0; i < ROM_WORDS; i++) begin
      rom[i] = '0;
    end
    for (int i = 0; i < RAM_WORDS; i++) begin
      ram[i]       = isa_pkg::xword_t'(5 * i);  // Word i holds 5*i
      model_ram[i] = isa_pkg::xword_t'(5 * i);
    end
    for (int i = 0; i < `NUM_REGS; i++) begin
      model_regs[i] = (i == `ZERO_REG) ? '0 : isa_pkg::xword_t'(i);
    end
    rom_fill = 0;
  endtask

  task automatic finish_test();
    int limit;
    int waited;
    limit  = rom_fill + 16;  // Pipeline fill plus branch refetch
    waited = 0;
    wait (rst === 1'b0);
    while ((exp_reg.size() != 0 || exp_addr.size() != 0) && waited < limit) begin
      @(posedge CLOCK);
      waited++;
    end
    repeat (6) @(posedge CLOCK);  // Catch anything retiring late
    if (exp_reg.size() != 0 || exp_addr.size() != 0) begin
      note_failure($sformatf("%0d register writes and %0d stores never happened",
                             exp_reg.size(), exp_addr.size()));
    end
    tests_run++;
    total_errors += test_errors;
    if (test_errors == 0) begin
      $display("PASS %s", test_name);
    end else begin
      tests_failed++;
      $display("FAIL %s with %0d errors", test_name, test_errors);
    end
  endtask

  task automatic alu_ops_test();
    prepare_test("alu_ops");
    alu_step(isa_pkg::OP_ADD, 1, 2, 3);
    alu_step(isa_pkg::OP_SUB, 4, 10, 3);
    alu_step(isa_pkg::OP_AND, 5, 12, 10);
    alu_step(isa_pkg::OP_ORR, 6, 12, 3);
    alu_step(isa_pkg::OP_SUB, 7, 3, 20);  // Wraps below zero
    finish_test();
  endtask

  task automatic forwarding_test();
    prepare_test("forwarding");
    alu_step(isa_pkg::OP_ADD, 1, 2, 3);
    alu_step(isa_pkg::OP_ADD, 1, 1, 1);
    alu_step(isa_pkg::OP_ADD, 2, 1, 4);  // Both stages hold x1, newest wins
    alu_step(isa_pkg::OP_SUB, 3, 2, 1);
    alu_step(isa_pkg::OP_ORR, 5, 1, 3);
    alu_step(isa_pkg::OP_AND, 6, 3, 5);
    finish_test();
  endtask

  task automatic load_store_test();
    prepare_test("load_store");
    load_step(1, 2, 9'd3);
    load_step(3, 10, 9'h1fe);  // Offset -2
    alu_step(isa_pkg::OP_ADD, 4, 5, 6);
    store_step(4, 7, 9'd1);
    alu_step(isa_pkg::OP_ADD, 8, 1, 3);
    store_step(8, 0, 9'd20);
    load_step(9, 7, 9'd1);
    finish_test();
  endtask

  task automatic load_use_test();
    prepare_test("load_use");
    load_step(1, 2, 9'd4);
    alu_step(isa_pkg::OP_ADD, 3, 1, 2);
    load_step(4, 1, 9'd0);
    alu_step(isa_pkg::OP_ADD, 5, 4, 4);
    load_step(7, 0, 9'd12);
    store_step(7, 0, 9'd40);  // Store data from the load just before
    alu_step(isa_pkg::OP_ADD, 6, 3, 5);
    finish_test();
  endtask

  task automatic branch_test();
    prepare_test("branches");
    place_word({isa_pkg::OP_B, 26'd6});
    shadow_words();
    place_word('0);
    place_word('0);
    alu_step(isa_pkg::OP_ADD, 4, 5, 6);
    alu_step(isa_pkg::OP_SUB, 7, 7, 7);
    place_word({isa_pkg::OP_CBZ, 19'd4, 5'd7});  // Taken, x7 is zero
    shadow_words();
    alu_step(isa_pkg::OP_ADD, 10, 4, 7);
    place_word({isa_pkg::OP_CBZ, 19'd4, 5'd10});  // Not taken
    alu_step(isa_pkg::OP_ADD, 11, 10, 1);
    alu_step(isa_pkg::OP_ORR, 12, 11, 4);
    store_step(12, 0, 9'd3);
    alu_step(isa_pkg::OP_ADD, 13, 12, 12);
    finish_test();
  endtask

  task automatic zero_random_test();
    isa_pkg::opcode_t ops [4];
    ops[0] = isa_pkg::OP_ADD;
    ops[1] = isa_pkg::OP_SUB;
    ops[2] = isa_pkg::OP_AND;
    ops[3] = isa_pkg::OP_ORR;
    prepare_test("zero_reg_random");
    alu_step(isa_pkg::OP_ADD, 31, 1, 2);
    alu_step(isa_pkg::OP_ADD, 1, 31, 5);
    load_step(31, 2, 9'd0);
    alu_step(isa_pkg::OP_ADD, 3, 31, 31);
    store_step(31, 0, 9'd7);
    place_word({isa_pkg::OP_CBZ, 19'd4, 5'd31});  // Always taken
    shadow_words();
    for (int i = 0; i < 12; i++) begin
      alu_step(ops[$urandom_range(3, 0)], isa_pkg::reg_addr_t'($urandom_range(31, 0)),
               isa_pkg::reg_addr_t'($urandom_range(31, 0)),
               isa_pkg::reg_addr_t'($urandom_range(31, 0)));
    end
    finish_test();
  endtask

  initial begin
    reset_req    = 1'b0;
    pend_we      = 1'b0;
    pend_addr    = '0;
    pend_data    = '0;
    rom_fill     = 0;
    test_name    = "init";
    test_errors  = 0;
    total_errors = 0;
    tests_run    = 0;
    tests_failed = 0;
    checks       = 0;
    cycles       = 0;
    for (int i = 0; i < ROM_WORDS; i++) begin
      rom[i] = '0;
    end
    for (int i = 0; i < RAM_WORDS; i++) begin
      ram[i]       = isa_pkg::xword_t'(5 * i);
      model_ram[i] = isa_pkg::xword_t'(5 * i);
    end
    void'($urandom(32'h5202));
    alu_ops_test();
    forwarding_test();
    load_store_test();
    load_use_test();
    branch_test();
    zero_random_test();
    $display("%0d tests run, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, total_errors);
    if (tests_failed == 0 && total_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+verilog
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/stage_reg.sv
verilog/fetch_unit.sv
verilog/reg_file.sv
verilog/decode_unit.sv
verilog/execute_unit.sv
verilog/legv8_core.sv
verif/tb_clock.sv
verif/legv8_props.sv
verif/legv8_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= legv8_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then \
	  echo "Simulation reported failure, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
